// ==== channel_adder_top.f ====
channel_adder_pkg.sv
line_buffer.sv
channel_sequencer.sv
add_stage.sv
adder_tree.sv
channel_adder_top.sv
channel_adder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the channel adder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module channel_adder_tb \
  -f channel_adder_top.f \
  -o channel_adder_sim

status=0
output=$(./obj_dir/channel_adder_sim 2>&1) || status=$?
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
  exit 0
else
  echo "Simulation did not pass, exit status ${status}"
  exit 1
fi

// ==== channel_adder_tb.sv ====
`default_nettype none

module channel_adder_tb;

  localparam int unsigned SEED = 32'hfb49_31cd;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int CH = channel_adder_pkg::CHANNEL_NUM;
  localparam int PS = channel_adder_pkg::PLANE_SIZE;
  localparam int PW = channel_adder_pkg::PIXEL_WIDTH;

  localparam channel_adder_pkg::pixel_t PIXEL_MAX = {1'b0, {(PW-1){1'b1}}};
  localparam channel_adder_pkg::pixel_t PIXEL_MIN = {1'b1, {(PW-1){1'b0}}};

  logic                      clk;
  logic                      reset;
  logic                      valid_in;
  channel_adder_pkg::pixel_t pxl_in;
  channel_adder_pkg::sum_t   pxl_out;
  logic                      valid_out;

  // Model of the frame being sent, channel by position
  channel_adder_pkg::pixel_t frame [CH][PS];

  channel_adder_pkg::sum_t exp_sum_q [$];
  int                      exp_cycle_q [$];

  int    cycle_cnt = 0;
  int    out_count;
  string test_name;

  channel_adder_top i_dut (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .pxl_out  (pxl_out),
    .valid_out(valid_out)
  );

  always #4 clk = ~clk;

  // Index of the cycle that follows each rising edge
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////
  // Reference and checks
  //////////////////////////////

  function automatic channel_adder_pkg::sum_t sum_position(input int pos);
    int acc;
    acc = 0;
    for (int c = 0; c < CH; c++) begin
      acc += int'(frame[c][pos]);
    end
    return channel_adder_pkg::sum_t'(acc);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_sum(input string name, input channel_adder_pkg::sum_t exp,
                           input channel_adder_pkg::sum_t act);
    if (act !== exp) begin
      fail_run($sformatf("Error: %s sum expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("Error: %s output count expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("Error: %s output cycle expected %0d actual %0d", name, exp, act));
    end
  endtask

  // Outputs sampled mid-cycle, away from the clock edge
  // Stray outputs with nothing queued show up in the count
  always @(negedge clk) begin
    if (valid_out) begin
      out_count++;
      if (exp_sum_q.size() != 0) begin
        if (exp_cycle_q.size() == 0) begin
          fail_run($sformatf("In %s valid_out rose with no last-channel input behind it",
                             test_name));
        end else begin
          check_sum(test_name, exp_sum_q.pop_front(), pxl_out);
          check_cycle(test_name, exp_cycle_q.pop_front() + channel_adder_pkg::LATENCY,
                      cycle_cnt);
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic queue_frame_sums();
    for (int p = 0; p < PS; p++) begin
      exp_sum_q.push_back(sum_position(p));
    end
  endtask

  task automatic make_random_frame();
    for (int c = 0; c < CH; c++) begin
      for (int p = 0; p < PS; p++) begin
        frame[c][p] = channel_adder_pkg::pixel_t'($urandom);
      end
    end
    queue_frame_sums();
  endtask

  task automatic make_const_frame(input channel_adder_pkg::pixel_t value);
    for (int c = 0; c < CH; c++) begin
      for (int p = 0; p < PS; p++) begin
        frame[c][p] = value;
      end
    end
    queue_frame_sums();
  endtask

  // Up to max_gap idle cycles before each pixel
  task automatic send_frame(input int max_gap);
    int gaps;
    for (int c = 0; c < CH; c++) begin
      for (int p = 0; p < PS; p++) begin
        gaps = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
        repeat (gaps) begin
          @(posedge clk);
          valid_in <= 1'b0;
          pxl_in   <= channel_adder_pkg::pixel_t'($urandom);
        end
        @(posedge clk);
        valid_in <= 1'b1;
        pxl_in   <= frame[c][p];
        // Sample sits on the wire during the next cycle
        if (c == CH-1) begin
          exp_cycle_q.push_back(cycle_cnt + 1);
        end
      end
    end
  endtask

  task automatic send_partial(input int samples);
    for (int i = 0; i < samples; i++) begin
      @(posedge clk);
      valid_in <= 1'b1;
      pxl_in   <= channel_adder_pkg::pixel_t'($urandom);
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    valid_in <= 1'b0;
    pxl_in   <= '0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset    <= 1'b1;
    valid_in <= 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    out_count = 0;
  endtask

  task automatic wait_drain(input int expected_outputs);
    int waited;
    waited = 0;
    while (exp_sum_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_sum_q.size() != 0) begin
      fail_run($sformatf("Timeout in %s, %0d sums never came out",
                         test_name, exp_sum_q.size()));
    end
    // A few more cycles to catch any stray output
    repeat (channel_adder_pkg::LATENCY + 2) @(negedge clk);
    check_count(test_name, expected_outputs, out_count);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    valid_in  = 1'b0;
    pxl_in    = '0;
    out_count = 0;
    test_name = "reset";
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    // Idle stretch first, then a single frame
    start_test("first_frame");
    repeat (10) @(posedge clk);
    make_random_frame();
    send_frame(0);
    go_idle();
    wait_drain(PS);

    start_test("back_to_back");
    for (int f = 0; f < 4; f++) begin
      make_random_frame();
      send_frame(0);
    end
    go_idle();
    wait_drain(4 * PS);

    start_test("random_gaps");
    for (int f = 0; f < 4; f++) begin
      make_random_frame();
      send_frame(3);
    end
    go_idle();
    wait_drain(4 * PS);

    start_test("extreme_values");
    make_const_frame(PIXEL_MAX);
    send_frame(0);
    make_const_frame(PIXEL_MIN);
    send_frame(0);
    go_idle();
    wait_drain(2 * PS);

    // Partial frame is thrown away by the reset
    start_test("mid_frame_reset");
    send_partial(3 * PS + 5);
    apply_reset();
    make_random_frame();
    send_frame(0);
    go_idle();
    wait_drain(PS);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== channel_adder_top.sv ====
`default_nettype none

module channel_adder_top (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            valid_in,
  input  wire channel_adder_pkg::pixel_t pxl_in,
  output channel_adder_pkg::sum_t        pxl_out,
  output logic                           valid_out
);

  //////////////////////////////
  // Delay line chain
  //////////////////////////////

  // chain[k] holds channel c-k while channel c arrives
  channel_adder_pkg::pixel_t chain [channel_adder_pkg::CHANNEL_NUM];
  channel_adder_pkg::pixel_t taps  [channel_adder_pkg::CHANNEL_NUM];

  channel_adder_pkg::pixel_t tap_0;

  logic last_channel;
  logic valid_q;
  logic last_channel_q;
  logic tree_valid;

  // Cycles since reset, saturating at LATENCY
  logic [$clog2(channel_adder_pkg::LATENCY+1)-1:0] since_reset;

  assign chain[0] = pxl_in;

  for (genvar k = 0; k < channel_adder_pkg::CHANNEL_NUM-1; k++) begin : g_line
    line_buffer #(
      .DEPTH(channel_adder_pkg::PLANE_SIZE)
    ) i_line_buffer (
      .clk     (clk),
      .reset   (reset),
      .valid_in(valid_in),
      .data_in (chain[k]),
      .data_out(chain[k+1]),
      .tap     (taps[k+1])
    );
  end

  //////////////////////////////
  // Tap 0 and enable
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (valid_in) begin
      tap_0 <= pxl_in;
    end
  end

  assign taps[0] = tap_0;

  channel_sequencer i_channel_sequencer (
    .clk         (clk),
    .reset       (reset),
    .valid_in    (valid_in),
    .last_channel(last_channel)
  );

  // Enable registered alongside the taps
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q        <= 1'b0;
      last_channel_q <= 1'b0;
    end else begin
      valid_q        <= valid_in;
      last_channel_q <= last_channel;
    end
  end

  assign tree_valid = valid_q && last_channel_q;

  //////////////////////////////
  // Reduction
  //////////////////////////////

  adder_tree i_adder_tree (
    .clk      (clk),
    .reset    (reset),
    .valid_in (tree_valid),
    .taps     (taps),
    .sum      (pxl_out),
    .valid_out(valid_out)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      since_reset <= '0;
    end else if (since_reset != channel_adder_pkg::LATENCY) begin
      since_reset <= since_reset + 1'b1;
    end
  end

  // Pipeline is empty right after reset
  a_quiet_after_reset : assert property (
    @(posedge clk) disable iff (reset)
    (since_reset < channel_adder_pkg::LATENCY) |-> !valid_out
  );

endmodule

`default_nettype wire

// ==== adder_tree.sv ====
`default_nettype none

module adder_tree (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            valid_in,
  input  wire channel_adder_pkg::pixel_t taps [channel_adder_pkg::CHANNEL_NUM],
  output channel_adder_pkg::sum_t        sum,
  output logic                           valid_out
);

  //////////////////////////////
  // Node storage
  //////////////////////////////

  // All tree nodes, level by level, leaves first and root last,
  // each held sign-extended to the full sum width
  channel_adder_pkg::sum_t node [2*channel_adder_pkg::CHANNEL_NUM-1];

  logic [channel_adder_pkg::TREE_DEPTH:0] valid_chain;

  assign valid_chain[0] = valid_in;

  for (genvar j = 0; j < channel_adder_pkg::CHANNEL_NUM; j++) begin : g_leaf
    assign node[j] = channel_adder_pkg::sum_t'(taps[j]);
  end

  //////////////////////////////
  // Tree levels
  //////////////////////////////

  for (genvar lvl = 0; lvl < channel_adder_pkg::TREE_DEPTH; lvl++) begin : g_level
    logic signed [channel_adder_pkg::PIXEL_WIDTH+lvl-1:0]
      operands [channel_adder_pkg::CHANNEL_NUM >> lvl];
    logic signed [channel_adder_pkg::PIXEL_WIDTH+lvl:0]
      sums [channel_adder_pkg::CHANNEL_NUM >> (lvl+1)];

    // Level inputs at their true width
    for (genvar j = 0; j < (channel_adder_pkg::CHANNEL_NUM >> lvl); j++) begin : g_in
      assign operands[j] = node[2*channel_adder_pkg::CHANNEL_NUM -
                                ((2*channel_adder_pkg::CHANNEL_NUM) >> lvl) + j]
                               [channel_adder_pkg::PIXEL_WIDTH+lvl-1:0];
    end

    add_stage #(
      .IN_COUNT(channel_adder_pkg::CHANNEL_NUM >> lvl),
      .IN_WIDTH(channel_adder_pkg::PIXEL_WIDTH + lvl)
    ) i_add_stage (
      .clk      (clk),
      .reset    (reset),
      .valid_in (valid_chain[lvl]),
      .operands (operands),
      .sums     (sums),
      .valid_out(valid_chain[lvl+1])
    );

    for (genvar j = 0; j < (channel_adder_pkg::CHANNEL_NUM >> (lvl+1)); j++) begin : g_out
      assign node[2*channel_adder_pkg::CHANNEL_NUM -
                  (channel_adder_pkg::CHANNEL_NUM >> lvl) + j] =
        channel_adder_pkg::sum_t'(sums[j]);
    end
  end

  // Root node is the last entry
  assign sum       = node[2*channel_adder_pkg::CHANNEL_NUM-2];
  assign valid_out = valid_chain[channel_adder_pkg::TREE_DEPTH];

endmodule

`default_nettype wire

// ==== add_stage.sv ====
`default_nettype none

module add_stage #(
  parameter int IN_COUNT = 8,
  parameter int IN_WIDTH = 16
) (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       valid_in,
  input  wire  signed [IN_WIDTH-1:0] operands [IN_COUNT],
  output logic signed [IN_WIDTH:0]   sums     [IN_COUNT/2],
  output logic                      valid_out
);

  //////////////////////////////
  // Pairwise adders
  //////////////////////////////

  // Element i pairs with element i + IN_COUNT/2, the split-half order
  always_ff @(posedge clk) begin
    if (valid_in) begin
      for (int i = 0; i < IN_COUNT/2; i++) begin
        sums[i] <= (IN_WIDTH+1)'(operands[i]) +
                   (IN_WIDTH+1)'(operands[i + IN_COUNT/2]);
      end
    end
  end

  //////////////////////////////
  // Valid pipeline
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= valid_in;
    end
  end

  // Exactly one cycle through each level
  a_one_cycle_level : assert property (
    @(posedge clk) disable iff (reset)
    !$past(reset) |-> (valid_out == $past(valid_in))
  );

endmodule

`default_nettype wire

// ==== channel_sequencer.sv ====
`default_nettype none

module channel_sequencer (
  input  wire  clk,
  input  wire  reset,
  input  wire  valid_in,
  output logic last_channel
);

  //////////////////////////////
  // Frame counters
  //////////////////////////////

  channel_adder_pkg::pos_idx_t  pos_cnt;
  channel_adder_pkg::chan_idx_t chan_cnt;

  logic pos_last;
  logic chan_last;

  assign pos_last  = (pos_cnt ==
                      channel_adder_pkg::pos_idx_t'(channel_adder_pkg::PLANE_SIZE - 1));
  assign chan_last = (chan_cnt ==
                      channel_adder_pkg::chan_idx_t'(channel_adder_pkg::CHANNEL_NUM - 1));

  // Position runs fastest, channel steps at the end of each plane
  always_ff @(posedge clk) begin
    if (reset) begin
      pos_cnt  <= '0;
      chan_cnt <= '0;
    end else if (valid_in) begin
      if (pos_last) begin
        pos_cnt <= '0;
        if (chan_last) begin
          chan_cnt <= '0;
        end else begin
          chan_cnt <= chan_cnt + 1'b1;
        end
      end else begin
        pos_cnt <= pos_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Last channel flag
  //////////////////////////////

  // High for every pixel of the final plane
  assign last_channel = valid_in && chan_last;

  a_last_needs_valid : assert property (
    @(posedge clk) disable iff (reset)
    last_channel |-> valid_in
  );

endmodule

`default_nettype wire

// ==== line_buffer.sv ====
`default_nettype none

module line_buffer #(
  parameter int DEPTH = 16
) (
  input  wire                            clk,
  input  wire                            reset,
  input  wire                            valid_in,
  input  wire channel_adder_pkg::pixel_t data_in,
  output channel_adder_pkg::pixel_t      data_out,
  output channel_adder_pkg::pixel_t      tap
);

  //////////////////////////////
  // Delay storage
  //////////////////////////////

  channel_adder_pkg::pixel_t mem [DEPTH];

  // Whole line moves one place per valid sample
  always_ff @(posedge clk) begin
    if (valid_in) begin
      mem[0] <= data_in;
      for (int i = 1; i < DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // Oldest entry, DEPTH valid samples behind data_in
  assign data_out = mem[DEPTH-1];

  // Tap captures the delayed sample, so it lines up with the
  // register on the undelayed stream in the top
  always_ff @(posedge clk) begin
    if (valid_in) begin
      tap <= data_out;
    end
  end

endmodule

`default_nettype wire

// ==== channel_adder_pkg.sv ====
`default_nettype none

package channel_adder_pkg;

  //////////////////////////////
  // Frame geometry
  //////////////////////////////

  // Channels per frame, must be a power of two
  localparam int CHANNEL_NUM = 8;

  // Pixels per plane, also the delay line length
  localparam int PLANE_SIZE = 16;

  localparam int PIXEL_WIDTH = 16;

  //////////////////////////////
  // Adder tree sizing
  //////////////////////////////

  localparam int TREE_DEPTH = $clog2(CHANNEL_NUM);

  // One extra bit per level, so the sum never wraps
  localparam int SUM_WIDTH = PIXEL_WIDTH + TREE_DEPTH;

  // Tap register plus one cycle per tree level
  localparam int LATENCY = TREE_DEPTH + 1;

  localparam int CHAN_IDX_WIDTH = $clog2(CHANNEL_NUM);
  localparam int POS_IDX_WIDTH  = $clog2(PLANE_SIZE);

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
  typedef logic signed [SUM_WIDTH-1:0]   sum_t;
  typedef logic [CHAN_IDX_WIDTH-1:0]     chan_idx_t;
  typedef logic [POS_IDX_WIDTH-1:0]      pos_idx_t;

endpackage

`default_nettype wire
